/* hw/coreCfgPkg.sv */
package coreCfgPkg;

    localparam int dataWidth    = 32;
    localparam int regCount     = 32;
    localparam int regAddrWidth = 5;

    // data word that also carries addresses and pc
    typedef logic [dataWidth-1:0] dataWordT;

    // instructions are fixed 32 bits in RV32I
    typedef logic [31:0] instrWordT;

    typedef logic [regAddrWidth-1:0] regAddrT;

endpackage

/* hw/rvIsaPkg.sv */
package rvIsaPkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcodeT;

    // funct3 codes overlap between groups (add/beq and sll/bne)
    typedef logic [2:0] funct3T;

    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;
    localparam funct3T f3Beq    = 3'b000;
    localparam funct3T f3Bne    = 3'b001;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluXor = 3'b100,
        aluSll = 3'b101
    } aluOpT;

    typedef enum logic [1:0] {
        immI = 2'b00,
        immS = 2'b01,
        immB = 2'b10,
        immJ = 2'b11
    } immSrcT;

    // write-back source
    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrcT;

    typedef enum logic [1:0] {
        pcPlus4  = 2'b00,
        pcTarget = 2'b01, // pc + imm
        pcAluOut = 2'b10  // jalr target
    } pcSrcT;

endpackage

/* hw/ctrlIf.sv */
`timescale 1ns/1ps

interface ctrlIf import rvIsaPkg::*; ();

    logic      regWrite;
    logic      aluSrc;    // 1 selects the immediate
    immSrcT    immSrc;
    aluOpT     aluOp;
    resultSrcT resultSrc;
    pcSrcT     pcSrc;
    logic      zero;      // alu zero flag for branches

    modport decoder (
        output regWrite, aluSrc, immSrc, aluOp, resultSrc, pcSrc,
        input  zero
    );

    modport exec (
        input  regWrite, aluSrc, immSrc, aluOp, resultSrc, pcSrc,
        output zero
    );

endinterface

/* hw/alu.sv */
`timescale 1ns/1ps

module alu
    import coreCfgPkg::*;
    import rvIsaPkg::*;
(
    input  dataWordT a,
    input  dataWordT b,
    input  aluOpT    op,
    output dataWordT result,
    output logic     zero
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSll:  result = a << b[4:0]; // only low 5 bits shift
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile
    import coreCfgPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  regAddrT  readAddr1,
    input  regAddrT  readAddr2,
    input  regAddrT  writeAddr,
    input  logic     writeEn,
    input  dataWordT writeData,
    output dataWordT readData1,
    output dataWordT readData2
);

    dataWordT regs [regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++)
                regs[i] <= '0;
        end else if (writeEn && writeAddr != '0) begin // x0 never written
            regs[writeAddr] <= writeData;
        end
    end

    // async reads
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

/* hw/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
    import coreCfgPkg::*;
    import rvIsaPkg::*;
(
    input  instrWordT instr,
    ctrlIf.decoder    ctrl,
    output logic      memWrite
);

    opcodeT opcode;
    funct3T funct3;
    logic   funct7b5;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30]; // sub vs add

    always_comb begin
        // defaults give a no-op for anything not listed
        ctrl.regWrite  = 1'b0;
        ctrl.aluSrc    = 1'b0;
        ctrl.immSrc    = immI;
        ctrl.aluOp     = aluAdd;
        ctrl.resultSrc = resAlu;
        ctrl.pcSrc     = pcPlus4;
        memWrite       = 1'b0;

        case (opcode)
            opR: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    f3AddSub: ctrl.aluOp = funct7b5 ? aluSub : aluAdd;
                    f3Xor:    ctrl.aluOp = aluXor;
                    f3Or:     ctrl.aluOp = aluOr;
                    f3And:    ctrl.aluOp = aluAnd;
                    default:  ctrl.aluOp = aluAdd;
                endcase
            end
            opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immI;
                if (funct3 == f3Sll)
                    ctrl.aluOp = aluSll; // slli takes shamt from imm[4:0]
                else
                    ctrl.aluOp = aluAdd;
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = immI;
                ctrl.resultSrc = resMem;
            end
            opStore: begin
                ctrl.aluSrc = 1'b1;
                ctrl.immSrc = immS;
                memWrite    = 1'b1;
            end
            opBranch: begin
                ctrl.immSrc = immB;
                ctrl.aluOp  = aluSub; // compare rs1 and rs2 through zero
                case (funct3)
                    f3Beq:   ctrl.pcSrc = ctrl.zero ? pcTarget : pcPlus4;
                    f3Bne:   ctrl.pcSrc = ctrl.zero ? pcPlus4 : pcTarget;
                    default: ctrl.pcSrc = pcPlus4;
                endcase
            end
            opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.immSrc    = immJ;
                ctrl.resultSrc = resPcPlus4; // link
                ctrl.pcSrc     = pcTarget;
            end
            opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = immI;
                ctrl.resultSrc = resPcPlus4;
                ctrl.pcSrc     = pcAluOut; // rs1 + imm
            end
            default: ;
        endcase
    end

endmodule

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath
    import coreCfgPkg::*;
    import rvIsaPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  instrWordT instr,
    ctrlIf.exec       ctrl,
    input  dataWordT  readData,
    output dataWordT  pc,
    output dataWordT  aluResult,
    output dataWordT  writeData
);

    regAddrT  rs1, rs2, rd;
    dataWordT rd1, rd2;
    dataWordT immExt;
    dataWordT srcB;
    dataWordT result;
    dataWordT pcPlus4Val, pcTargetVal, pcNext;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // sign-extended immediate per format
    always_comb begin
        case (ctrl.immSrc)
            immI: immExt = {{20{instr[31]}}, instr[31:20]};
            immS: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ: immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: immExt = '0;
        endcase
    end

    regFile rf0 (
        .clk       (clk),
        .arstN     (arstN),
        .readAddr1 (rs1),
        .readAddr2 (rs2),
        .writeAddr (rd),
        .writeEn   (ctrl.regWrite),
        .writeData (result),
        .readData1 (rd1),
        .readData2 (rd2)
    );

    assign srcB = ctrl.aluSrc ? immExt : rd2;

    alu alu0 (
        .a      (rd1),
        .b      (srcB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (ctrl.zero)
    );

    assign pcPlus4Val  = pc + 32'd4;
    assign pcTargetVal = pc + immExt;

    always_comb begin
        case (ctrl.resultSrc)
            resMem:     result = readData;
            resPcPlus4: result = pcPlus4Val; // jal/jalr link
            default:    result = aluResult;
        endcase
    end

    always_comb begin
        case (ctrl.pcSrc)
            pcTarget: pcNext = pcTargetVal;
            pcAluOut: pcNext = {aluResult[dataWidth-1:1], 1'b0};
            default:  pcNext = pcPlus4Val;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            pc <= '0;
        else
            pc <= pcNext;
    end

    assign writeData = rd2; // sw stores rs2

endmodule

/* hw/rvCore.sv */
`timescale 1ns/1ps

module rvCore
    import coreCfgPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  instrWordT instr,
    input  dataWordT  readData,
    output dataWordT  pc,
    output dataWordT  dataAddr,
    output dataWordT  writeData,
    output logic      memWrite
);

    dataWordT aluResult;

    // decoded control and branch flag
    ctrlIf ctrlBus ();

    controlUnit cu0 (
        .instr    (instr),
        .ctrl     (ctrlBus.decoder),
        .memWrite (memWrite)
    );

    datapath dp0 (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .ctrl      (ctrlBus.exec),
        .readData  (readData),
        .pc        (pc),
        .aluResult (aluResult),
        .writeData (writeData)
    );

    assign dataAddr = aluResult; // lw/sw address

endmodule

/* bench/tbRvCore.sv */
`timescale 1ns/1ps

module tbRvCore
    import coreCfgPkg::*;
();

    localparam int clkPeriod  = 100;
    localparam int driveDelay = 1;
    localparam int progDepth  = 64;
    localparam int storeBase  = 64;   // word index of the store list in the cases file
    localparam int finalSlot  = 127;  // word index of the final pc
    localparam logic [31:0] endMark = 32'hFFFF_FFFF;

    logic      clk;
    logic      arstN;
    instrWordT instr;
    dataWordT  readData;
    dataWordT  pc;
    dataWordT  dataAddr;
    dataWordT  writeData;
    logic      memWrite;

    logic [31:0] caseMem [0:127];  // raw image of the cases file
    instrWordT   progMem [0:progDepth-1];
    dataWordT    dataMem [0:63];
    dataWordT    expAddr [$];
    dataWordT    expData [$];
    dataWordT    finalPc;
    int          progLen;
    int          valueErrors;
    int          otherErrors;
    logic        loadDone;

    rvCore dut0 (
        .clk       (clk),
        .arstN     (arstN),
        .instr     (instr),
        .readData  (readData),
        .pc        (pc),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memWrite  (memWrite)
    );

    always #(clkPeriod / 2) clk = ~clk;

    function automatic instrWordT fetchInstr(dataWordT addr);
        if (addr < progDepth * 4)
            return progMem[addr[7:2]];
        return 32'h0000_0013; // addi x0, x0, 0 outside the program
    endfunction

    task automatic checkWord(string name, dataWordT got, dataWordT expected);
        if (got !== expected) begin
            valueErrors++;
            $display("** Error at %0t ns: %s got %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic checkPc(dataWordT got, dataWordT expected);
        if (got !== expected) begin
            valueErrors++;
            $display("** Error at %0t ns: pc got %h, expected %h", $time, got, expected);
        end
    endtask

    task automatic reportAndFinish();
        $display("errors: %0d wrong values, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    endtask

    // instruction and data memory answer just after the edge
    always @(posedge clk) begin
        #driveDelay instr = fetchInstr(pc);
        #driveDelay readData = dataMem[dataAddr[7:2]];
    end

    // data memory write port checks every store against the list
    always @(posedge clk) begin
        if (arstN && memWrite) begin
            if (expAddr.size() == 0) begin
                otherErrors++;
                $display("Error at %0t ns: store to %h was not expected", $time, dataAddr);
            end else begin
                checkWord("dataAddr", dataAddr, expAddr.pop_front());
                checkWord("writeData", writeData, expData.pop_front());
            end
            dataMem[dataAddr[7:2]] = writeData;
        end
    end

    initial begin
        int timeoutNs;
        wait (loadDone);
        timeoutNs = (progLen * 4 + 10) * clkPeriod;
        #(timeoutNs);
        otherErrors++;
        $display("Timeout: pc did not reach %h within %0d ns", finalPc, timeoutNs);
        reportAndFinish();
    end

    initial begin
        int i;
        clk         = 1'b0;
        arstN       = 1'b0;
        instr       = 32'h0000_0013;
        readData    = '0;
        valueErrors = 0;
        otherErrors = 0;
        loadDone    = 1'b0;

        for (i = 0; i < 128; i++)
            caseMem[i] = endMark; // unused words read as the end marker
        $readmemh("bench/rvCoreCases.txt", caseMem);

        progLen = 0;
        while (progLen < progDepth && caseMem[progLen] != endMark) begin
            progMem[progLen] = caseMem[progLen];
            progLen++;
        end
        for (i = progLen; i < progDepth; i++)
            progMem[i] = 32'h0000_0013;
        i = storeBase;
        while (i < finalSlot - 1 && caseMem[i] != endMark) begin
            expAddr.push_back(caseMem[i]);
            expData.push_back(caseMem[i + 1]);
            i += 2;
        end
        finalPc = caseMem[finalSlot];
        for (i = 0; i < 64; i++)
            dataMem[i] = 32'hDA00_0000 ^ (dataWordT'(i) << 2); // byte address in the fill
        instr    = progMem[0];
        loadDone = 1'b1;

        repeat (2) @(posedge clk);
        #driveDelay arstN = 1'b1;
        checkPc(pc, '0); // first pc out of reset

        while (pc !== finalPc) begin
            @(posedge clk);
            #(clkPeriod / 10);
        end
        // the last instruction jumps onto itself
        repeat (3) begin
            @(posedge clk);
            #(clkPeriod / 10);
            checkPc(pc, finalPc);
        end

        if (expAddr.size() != 0) begin
            otherErrors++;
            $display("Error: %0d expected stores never happened, next one to %h",
                     expAddr.size(), expAddr[0]);
        end
        reportAndFinish();
    end

endmodule

/* bench/rvCoreCases.txt */
// words 0x00..: program, one instruction per word, end at first FFFFFFFF
// words 0x40..: expected stores as address data pairs, FFFFFFFF ends; word 0x7F: final pc
@00
00C00093 00500113 002081B3 40208233  // addi x1=12, addi x2=5, add x3, sub x4
0020F2B3 0020E333 0020C3B3 00411413  // and x5, or x6, xor x7, slli x8=x2<<4
04302023 04402223 04502423 04602623  // sw x3..x6 to 0x40..0x4c
04702823 04802A23 FFD00493 04902C23  // sw x7, sw x8, addi x9=-3, sw x9 to 0x58
00842503 04A02E23 00208463 06102023  // lw x10 8(x8), sw x10, beq not taken, sw x1
00108463 06202223 00109463 06202423  // beq taken, skipped sw, bne not taken, sw x2
00209463 06102623 00C005EF 06B02823  // bne taken, skipped sw, jal x11 +12, sw x11
00C0006F 06B02A23 00058067 06300013  // jal x0 +12, sw link, jalr x0 0(x11), addi x0
06002C23 000000FF 06102E23 0000006F  // sw x0, bad opcode, sw x1, jal x0 0
@40
00000040 00000011  00000044 00000007  // add, sub
00000048 00000004  0000004C 0000000D  // and, or
00000050 00000009  00000054 00000050  // xor, slli
00000058 FFFFFFFD  0000005C FFFFFFFD  // negative addi, lw copy
00000060 0000000C  00000068 00000005  // fall-through stores
00000074 0000006C  00000070 0000006C  // link inside the call, after jalr return
00000078 00000000  0000007C 0000000C  // x0 and after the bad opcode
FFFFFFFF
@7F
0000008C

/* rvCore.f */
hw/coreCfgPkg.sv
hw/rvIsaPkg.sv
hw/ctrlIf.sv
hw/alu.sv
hw/regFile.sv
hw/controlUnit.sv
hw/datapath.sv
hw/rvCore.sv
bench/tbRvCore.sv

/* runSim.sh */
#!/bin/sh
# build and run the rvCore testbench with Verilator, run from the project root

rm -f sim.log

verilator --binary -Wno-fatal -f rvCore.f --top-module tbRvCore -o simRvCore \
    && ./obj_dir/simRvCore | tee sim.log \
    && ! grep -q "Finished with errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
